/* include/aes_macros.svh */
////////////////////////////////////////////////////////////
// AES engine parameters
// Block, key and register-bus widths, the register map
// offsets and the number of cipher rounds
////////////////////////////////////////////////////////////
`ifndef AES_MACROS_SVH
`define AES_MACROS_SVH

// Cipher widths
`define AES_BLOCK_W 128
`define AES_KEY_W 128
`define AES_NROUNDS 10

// AXI4-Lite bus widths
`define LITE_ADDR_W 10
`define LITE_DATA_W 32

// Register offsets with KEY0 as the most significant key word
`define REG_KEY0 10'h000
`define REG_KEY1 10'h004
`define REG_KEY2 10'h008
`define REG_KEY3 10'h00c
`define REG_CTRL 10'h010
`define REG_STATUS 10'h014
`define REG_COUNT 10'h018

`endif

/* hw/axi_pkg.sv */
////////////////////////////////////////////////////////////
// AXI4-Lite register bus types
// Address, data word and response code
////////////////////////////////////////////////////////////
`default_nettype none

`include "aes_macros.svh"

package axi_pkg;

   typedef logic [`LITE_ADDR_W-1:0] lite_addr_t;
   typedef logic [`LITE_DATA_W-1:0] lite_data_t;
   typedef logic [1:0] resp_t;

   // Response codes
   localparam resp_t RESP_OKAY = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* hw/aes_pkg.sv */
////////////////////////////////////////////////////////////
// AES-128 types and round functions
// Byte 0 of a block is its most significant byte, state is
// stored column by column as in FIPS-197
////////////////////////////////////////////////////////////
`default_nettype none

`include "aes_macros.svh"

package aes_pkg;

   typedef logic [`AES_BLOCK_W-1:0] aes_block_t;
   typedef logic [`AES_KEY_W-1:0] aes_key_t;
   // Element 0 is the cipher key itself
   typedef aes_key_t [0:`AES_NROUNDS] round_keys_t;
   typedef enum logic {KS_IDLE, KS_EXPAND} ks_state_t;

   // Multiply by x modulo the AES polynomial
   function automatic logic [7:0] xtime(input logic [7:0] b);
      return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
   endfunction

   function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
      logic [7:0] p;
      logic [7:0] x;
      p = 8'h00;
      x = a;
      for (int i = 0; i < 8; i++) begin
         if (b[i])
            p = p ^ x;
         x = xtime(x);
      end
      return p;
   endfunction

   // Inverse as x^254, then the affine map
   function automatic logic [7:0] sbox(input logic [7:0] x);
      logic [7:0] inv;
      logic [7:0] sq;
      inv = 8'h01;
      sq = x;
      for (int i = 1; i < 8; i++) begin
         sq = gf_mul(sq, sq);
         inv = gf_mul(inv, sq);
      end
      return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
             ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
   endfunction

   function automatic aes_block_t sub_bytes(input aes_block_t s);
      aes_block_t o;
      for (int i = 0; i < 16; i++)
         o[8*i +: 8] = sbox(s[8*i +: 8]);
      return o;
   endfunction

   // Row r rotates left by r columns
   function automatic aes_block_t shift_rows(input aes_block_t s);
      aes_block_t o;
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++)
            o[127-8*(4*c+r) -: 8] = s[127-8*(4*((c+r)%4)+r) -: 8];
      end
      return o;
   endfunction

   function automatic aes_block_t mix_columns(input aes_block_t s);
      aes_block_t o;
      logic [7:0] a0, a1, a2, a3;
      for (int c = 0; c < 4; c++) begin
         {a0, a1, a2, a3} = s[127-32*c -: 32];
         o[127-32*c -: 32] = {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                              a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                              a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                              xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
      end
      return o;
   endfunction

   // RotWord, SubWord and Rcon on the last word, then the word chain
   function automatic aes_key_t next_round_key(input aes_key_t k, input logic [7:0] rcon);
      logic [31:0] t;
      logic [31:0] w0, w1, w2, w3;
      t = {sbox(k[23:16]), sbox(k[15:8]), sbox(k[7:0]), sbox(k[31:24])}
          ^ {rcon, 24'h000000};
      w0 = k[127:96] ^ t;
      w1 = k[95:64] ^ w0;
      w2 = k[63:32] ^ w1;
      w3 = k[31:0] ^ w2;
      return {w0, w1, w2, w3};
   endfunction

endpackage

`default_nettype wire

/* hw/aes_stage_if.sv */
////////////////////////////////////////////////////////////
// Link between two neighboring cipher pipeline stages
// Block, valid and last flow downstream, advance is the
// pipeline-wide step enable
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

interface aes_stage_if;
   import aes_pkg::*;

   aes_block_t block;
   logic valid;
   logic last;
   // Same level on every link
   logic advance;

   modport source (output block, output valid, output last, input advance);
   modport sink (input block, input valid, input last, input advance);
endinterface

`default_nettype wire

/* hw/aes_lite_regs.sv */
////////////////////////////////////////////////////////////
// AXI4-Lite register slave of the AES engine
// Holds the key words, decodes CTRL into a load pulse,
// reports key status and counts delivered blocks
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "aes_macros.svh"

module aes_lite_regs (
   input  wire                      aclk,
   input  wire                      reset,
   input  wire                      s_axi_lite_awvalid,
   input  wire axi_pkg::lite_addr_t s_axi_lite_awaddr,
   input  wire                      s_axi_lite_wvalid,
   input  wire axi_pkg::lite_data_t s_axi_lite_wdata,
   input  wire                      s_axi_lite_bready,
   input  wire                      s_axi_lite_arvalid,
   input  wire axi_pkg::lite_addr_t s_axi_lite_araddr,
   input  wire                      s_axi_lite_rready,
   input  wire                      key_busy,
   input  wire                      key_ready,
   input  wire                      block_done,
   output logic                     s_axi_lite_awready,
   output logic                     s_axi_lite_wready,
   output logic                     s_axi_lite_bvalid,
   output axi_pkg::resp_t           s_axi_lite_bresp,
   output logic                     s_axi_lite_arready,
   output logic                     s_axi_lite_rvalid,
   output axi_pkg::lite_data_t      s_axi_lite_rdata,
   output axi_pkg::resp_t           s_axi_lite_rresp,
   output aes_pkg::aes_key_t        key,
   output logic                     key_load
);
   import axi_pkg::*;

   // Word 0 sits in the top bits of the key
   lite_data_t [0:3] key_words;
   lite_data_t block_count;
   lite_data_t rd_word;
   logic wr_en;
   logic rd_en;
   logic wr_ok;
   logic rd_ok;

   // Address and data taken together with one outstanding response
   assign wr_en = s_axi_lite_awvalid & s_axi_lite_wvalid & ~s_axi_lite_bvalid;
   assign rd_en = s_axi_lite_arvalid & ~s_axi_lite_rvalid;
   assign s_axi_lite_awready = wr_en;
   assign s_axi_lite_wready = wr_en;
   assign s_axi_lite_arready = rd_en;

   assign wr_ok = s_axi_lite_awaddr inside {`REG_KEY0, `REG_KEY1, `REG_KEY2, `REG_KEY3,
                                            `REG_CTRL, `REG_STATUS, `REG_COUNT};
   // Start pulse in the accept cycle
   assign key_load = wr_en && (s_axi_lite_awaddr == `REG_CTRL) && s_axi_lite_wdata[0];
   assign key = key_words;

   // Read mux
   always_comb begin
      rd_word = '0;
      rd_ok = 1'b1;
      case (s_axi_lite_araddr)
         `REG_KEY0: rd_word = key_words[0];
         `REG_KEY1: rd_word = key_words[1];
         `REG_KEY2: rd_word = key_words[2];
         `REG_KEY3: rd_word = key_words[3];
         `REG_CTRL: rd_word = '0;
         `REG_STATUS: rd_word[1:0] = {key_busy, key_ready};
         `REG_COUNT: rd_word = block_count;
         default: rd_ok = 1'b0;
      endcase
   end

   // Only the key words take write data
   always_ff @(posedge aclk) begin
      if (reset) begin
         key_words <= '0;
      end else if (wr_en) begin
         case (s_axi_lite_awaddr)
            `REG_KEY0: key_words[0] <= s_axi_lite_wdata;
            `REG_KEY1: key_words[1] <= s_axi_lite_wdata;
            `REG_KEY2: key_words[2] <= s_axi_lite_wdata;
            `REG_KEY3: key_words[3] <= s_axi_lite_wdata;
            default: ;
         endcase
      end
   end

   // Response valids held until taken
   always_ff @(posedge aclk) begin
      if (reset) begin
         s_axi_lite_bvalid <= 1'b0;
         s_axi_lite_rvalid <= 1'b0;
      end else begin
         if (wr_en)
            s_axi_lite_bvalid <= 1'b1;
         else if (s_axi_lite_bready)
            s_axi_lite_bvalid <= 1'b0;
         if (rd_en)
            s_axi_lite_rvalid <= 1'b1;
         else if (s_axi_lite_rready)
            s_axi_lite_rvalid <= 1'b0;
      end
   end

   // Response payload
   always_ff @(posedge aclk) begin
      if (wr_en)
         s_axi_lite_bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      if (rd_en) begin
         s_axi_lite_rdata <= rd_word;
         s_axi_lite_rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
      end
   end

   // One count per output transfer
   always_ff @(posedge aclk) begin
      if (reset)
         block_count <= '0;
      else if (block_done)
         block_count <= block_count + 1'b1;
   end

   bresp_held: assert property (@(posedge aclk) disable iff (reset)
      s_axi_lite_bvalid && !s_axi_lite_bready |=> s_axi_lite_bvalid);

   rdata_held: assert property (@(posedge aclk) disable iff (reset)
      s_axi_lite_rvalid && !s_axi_lite_rready |=> s_axi_lite_rvalid && $stable(s_axi_lite_rdata));

endmodule

`default_nettype wire

/* hw/aes_key_schedule.sv */
////////////////////////////////////////////////////////////
// Iterative AES-128 key expansion
// Loads the cipher key as round key 0 and derives one more
// round key per cycle
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "aes_macros.svh"

module aes_key_schedule (
   input  wire                    aclk,
   input  wire                    reset,
   input  wire aes_pkg::aes_key_t key,
   input  wire                    key_load,
   output aes_pkg::round_keys_t   round_keys,
   output logic                   key_busy,
   output logic                   key_ready
);
   import aes_pkg::*;

   ks_state_t state;
   // Index of the round key being computed
   logic [3:0] round_cnt;
   logic [7:0] rcon;

   assign key_busy = (state == KS_EXPAND);

   always_ff @(posedge aclk) begin
      if (reset) begin
         state <= KS_IDLE;
         round_cnt <= '0;
         rcon <= 8'h01;
         key_ready <= 1'b0;
      end else begin
         case (state)
            KS_IDLE: begin
               if (key_load) begin
                  state <= KS_EXPAND;
                  round_cnt <= 4'd1;
                  rcon <= 8'h01;
                  key_ready <= 1'b0;
               end
            end
            KS_EXPAND: begin
               rcon <= xtime(rcon);
               if (round_cnt == `AES_NROUNDS) begin
                  state <= KS_IDLE;
                  round_cnt <= '0;
                  key_ready <= 1'b1;
               end else begin
                  round_cnt <= round_cnt + 4'd1;
               end
            end
            default: state <= KS_IDLE;
         endcase
      end
   end

   // Loads while busy are dropped
   always_ff @(posedge aclk) begin
      if (state == KS_IDLE && key_load)
         round_keys[0] <= key;
      else if (state == KS_EXPAND)
         round_keys[round_cnt] <= next_round_key(round_keys[round_cnt - 4'd1], rcon);
   end

   round_cnt_range: assert property (@(posedge aclk) disable iff (reset)
      round_cnt <= `AES_NROUNDS);

endmodule

`default_nettype wire

/* hw/aes_ingress.sv */
////////////////////////////////////////////////////////////
// First cipher pipeline stage
// Takes the input stream beat and adds round key 0
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module aes_ingress (
   input  wire                      aclk,
   input  wire                      reset,
   input  wire aes_pkg::aes_block_t tdata,
   input  wire                      tvalid,
   input  wire                      tlast,
   input  wire aes_pkg::aes_key_t   round_key0,
   // Input ready that is high only on advance with a ready key
   input  wire                      accept,
   aes_stage_if.source              stage
);

   always_ff @(posedge aclk) begin
      if (reset)
         stage.valid <= 1'b0;
      else if (stage.advance)
         stage.valid <= tvalid & accept;
   end

   // Initial AddRoundKey
   always_ff @(posedge aclk) begin
      if (stage.advance) begin
         stage.block <= tdata ^ round_key0;
         stage.last <= tlast;
      end
   end

endmodule

`default_nettype wire

/* hw/aes_round.sv */
////////////////////////////////////////////////////////////
// Full AES round stage
// SubBytes, ShiftRows, MixColumns and AddRoundKey into the
// stage register, same logic for any round index
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module aes_round (
   input  wire                    aclk,
   input  wire                    reset,
   input  wire aes_pkg::aes_key_t round_key,
   aes_stage_if.sink              up,
   aes_stage_if.source            down
);
   import aes_pkg::*;

   aes_block_t round_out;

   assign round_out = mix_columns(shift_rows(sub_bytes(up.block))) ^ round_key;

   // Whole pipeline steps together
   always_ff @(posedge aclk) begin
      if (reset)
         down.valid <= 1'b0;
      else if (down.advance)
         down.valid <= up.valid;
   end

   always_ff @(posedge aclk) begin
      if (down.advance) begin
         down.block <= round_out;
         down.last <= up.last;
      end
   end

endmodule

`default_nettype wire

/* hw/aes_egress.sv */
////////////////////////////////////////////////////////////
// Final cipher stage and output stream driver
// Last round without MixColumns, derives the pipeline
// advance from the output handshake
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module aes_egress (
   input  wire                    aclk,
   input  wire                    reset,
   input  wire aes_pkg::aes_key_t round_key,
   aes_stage_if.sink              up,
   input  wire                    tready,
   output aes_pkg::aes_block_t    tdata,
   output logic                   tvalid,
   output logic                   tlast,
   output logic                   advance,
   output logic                   block_done
);
   import aes_pkg::*;

   aes_block_t final_out;

   assign final_out = shift_rows(sub_bytes(up.block)) ^ round_key;

   // Output register empty or being drained
   assign advance = ~tvalid | tready;
   assign block_done = tvalid & tready;

   always_ff @(posedge aclk) begin
      if (reset)
         tvalid <= 1'b0;
      else if (advance)
         tvalid <= up.valid;
   end

   always_ff @(posedge aclk) begin
      if (advance) begin
         tdata <= final_out;
         tlast <= up.last;
      end
   end

   // Stalled beat must not change
   out_stable: assert property (@(posedge aclk) disable iff (reset)
      tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tlast));

endmodule

`default_nettype wire

/* hw/axi_aes.sv */
////////////////////////////////////////////////////////////
// AES-128 encryption engine
// AXI4-Lite key and status registers, eleven-stage cipher
// pipeline from the mm2s stream to the s2mm stream
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "aes_macros.svh"

module axi_aes (
   input  wire                      aclk,
   input  wire                      reset,
   input  wire                      s_axi_lite_awvalid,
   input  wire axi_pkg::lite_addr_t s_axi_lite_awaddr,
   input  wire                      s_axi_lite_wvalid,
   input  wire axi_pkg::lite_data_t s_axi_lite_wdata,
   input  wire                      s_axi_lite_bready,
   input  wire                      s_axi_lite_arvalid,
   input  wire axi_pkg::lite_addr_t s_axi_lite_araddr,
   input  wire                      s_axi_lite_rready,
   input  wire aes_pkg::aes_block_t m_axis_mm2s_tdata,
   input  wire                      m_axis_mm2s_tvalid,
   input  wire                      m_axis_mm2s_tlast,
   input  wire                      s_axis_s2mm_tready,
   output logic                     s_axi_lite_awready,
   output logic                     s_axi_lite_wready,
   output logic                     s_axi_lite_bvalid,
   output axi_pkg::resp_t           s_axi_lite_bresp,
   output logic                     s_axi_lite_arready,
   output logic                     s_axi_lite_rvalid,
   output axi_pkg::lite_data_t      s_axi_lite_rdata,
   output axi_pkg::resp_t           s_axi_lite_rresp,
   output logic                     m_axis_mm2s_tready,
   output aes_pkg::aes_block_t      s_axis_s2mm_tdata,
   output logic                     s_axis_s2mm_tvalid,
   output logic                     s_axis_s2mm_tlast
);
   import aes_pkg::*;

   aes_key_t key;
   round_keys_t round_keys;
   logic key_load;
   logic key_busy;
   logic key_ready;
   logic advance;
   logic block_done;

   // Link g feeds stage g+1
   aes_stage_if link [0:`AES_NROUNDS-1] ();

   // Input only with a complete key schedule
   assign m_axis_mm2s_tready = advance & key_ready & ~key_busy;

   aes_lite_regs u_regs (
      .aclk, .reset,
      .s_axi_lite_awvalid, .s_axi_lite_awaddr, .s_axi_lite_wvalid, .s_axi_lite_wdata,
      .s_axi_lite_bready, .s_axi_lite_arvalid, .s_axi_lite_araddr, .s_axi_lite_rready,
      .key_busy, .key_ready, .block_done,
      .s_axi_lite_awready, .s_axi_lite_wready, .s_axi_lite_bvalid, .s_axi_lite_bresp,
      .s_axi_lite_arready, .s_axi_lite_rvalid, .s_axi_lite_rdata, .s_axi_lite_rresp,
      .key, .key_load
   );

   aes_key_schedule u_key_schedule (
      .aclk, .reset, .key, .key_load, .round_keys, .key_busy, .key_ready
   );

   aes_ingress u_ingress (
      .aclk, .reset,
      .tdata(m_axis_mm2s_tdata), .tvalid(m_axis_mm2s_tvalid), .tlast(m_axis_mm2s_tlast),
      .round_key0(round_keys[0]), .accept(m_axis_mm2s_tready), .stage(link[0])
   );

   // One advance level for every link
   for (genvar g = 0; g < `AES_NROUNDS; g++) begin : g_advance
      assign link[g].advance = advance;
   end

   // Rounds 1 to 9
   for (genvar r = 1; r < `AES_NROUNDS; r++) begin : g_round
      aes_round u_round (
         .aclk, .reset, .round_key(round_keys[r]), .up(link[r-1]), .down(link[r])
      );
   end

   aes_egress u_egress (
      .aclk, .reset, .round_key(round_keys[`AES_NROUNDS]), .up(link[`AES_NROUNDS-1]),
      .tready(s_axis_s2mm_tready), .tdata(s_axis_s2mm_tdata), .tvalid(s_axis_s2mm_tvalid),
      .tlast(s_axis_s2mm_tlast), .advance, .block_done
   );

endmodule

`default_nettype wire

/* sim/tb_axi_aes.sv */
////////////////////////////////////////////////////////////
// Self-checking testbench for the AES-128 engine
// Loads keys over AXI4-Lite, streams blocks through the
// cipher pipeline and scores them against a reference
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "aes_macros.svh"

module tb_axi_aes;
   import axi_pkg::*;
   import aes_pkg::*;

   localparam int TIMEOUT_CYCLES = 400;
   localparam int STATUS_POLLS = 20;

   logic aclk;
   logic reset;
   logic s_axi_lite_awvalid;
   lite_addr_t s_axi_lite_awaddr;
   logic s_axi_lite_wvalid;
   lite_data_t s_axi_lite_wdata;
   logic s_axi_lite_bready;
   logic s_axi_lite_arvalid;
   lite_addr_t s_axi_lite_araddr;
   logic s_axi_lite_rready;
   aes_block_t m_axis_mm2s_tdata;
   logic m_axis_mm2s_tvalid;
   logic m_axis_mm2s_tlast;
   logic s_axis_s2mm_tready;
   logic s_axi_lite_awready;
   logic s_axi_lite_wready;
   logic s_axi_lite_bvalid;
   resp_t s_axi_lite_bresp;
   logic s_axi_lite_arready;
   logic s_axi_lite_rvalid;
   lite_data_t s_axi_lite_rdata;
   resp_t s_axi_lite_rresp;
   logic m_axis_mm2s_tready;
   aes_block_t s_axis_s2mm_tdata;
   logic s_axis_s2mm_tvalid;
   logic s_axis_s2mm_tlast;

   integer seed = 32'hac12;
   int errors = 0;
   int checks = 0;
   int seen_count = 0;
   // Random output stalls while high
   logic bp_on = 1'b0;
   aes_key_t cur_key;
   // Expected beats with tlast on top of the ciphertext
   logic [`AES_BLOCK_W:0] exp_q[$];
   logic prev_stall;
   aes_block_t prev_data;
   logic prev_last;

   axi_aes UUT (.*);

   // Reference cipher expanding the key on the fly
   function automatic aes_block_t aes_ref(input aes_block_t pt, input aes_key_t k);
      aes_key_t rk;
      aes_block_t s;
      logic [7:0] rcon;
      rk = k;
      rcon = 8'h01;
      s = pt ^ rk;
      for (int r = 1; r <= `AES_NROUNDS; r++) begin
         rk = next_round_key(rk, rcon);
         rcon = xtime(rcon);
         if (r < `AES_NROUNDS)
            s = mix_columns(shift_rows(sub_bytes(s))) ^ rk;
         else
            s = shift_rows(sub_bytes(s)) ^ rk;
      end
      return s;
   endfunction

   function automatic logic [127:0] random_word128();
      return {$random(seed), $random(seed), $random(seed), $random(seed)};
   endfunction

   task automatic check_equal(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      errors++;
      $display("Timeout at %0t while waiting for %s", $time, what);
   endtask

   // Address and data together, then the write response
   task automatic lite_write(input lite_addr_t addr, input lite_data_t data,
                             output resp_t resp);
      int waited;
      logic taken;
      waited = 0;
      resp = RESP_SLVERR;
      s_axi_lite_awaddr = addr;
      s_axi_lite_wdata = data;
      s_axi_lite_awvalid = 1'b1;
      s_axi_lite_wvalid = 1'b1;
      @(negedge aclk);
      while (!s_axi_lite_awready && waited < TIMEOUT_CYCLES) begin
         @(negedge aclk);
         waited++;
      end
      taken = s_axi_lite_awready;
      // Data channel accepted in the same cycle as the address
      if (taken)
         check_equal("s_axi_lite_wready", s_axi_lite_wready, 1'b1);
      @(posedge aclk);
      #2;
      s_axi_lite_awvalid = 1'b0;
      s_axi_lite_wvalid = 1'b0;
      if (!taken) begin
         report_timeout("a write to be accepted");
      end else begin
         waited = 0;
         @(negedge aclk);
         while (!s_axi_lite_bvalid && waited < TIMEOUT_CYCLES) begin
            @(negedge aclk);
            waited++;
         end
         if (s_axi_lite_bvalid)
            resp = s_axi_lite_bresp;
         else
            report_timeout("a write response");
         @(posedge aclk);
         #2;
      end
   endtask

   task automatic lite_read(input lite_addr_t addr, output lite_data_t data,
                            output resp_t resp);
      int waited;
      logic taken;
      waited = 0;
      data = '0;
      resp = RESP_SLVERR;
      s_axi_lite_araddr = addr;
      s_axi_lite_arvalid = 1'b1;
      @(negedge aclk);
      while (!s_axi_lite_arready && waited < TIMEOUT_CYCLES) begin
         @(negedge aclk);
         waited++;
      end
      taken = s_axi_lite_arready;
      @(posedge aclk);
      #2;
      s_axi_lite_arvalid = 1'b0;
      if (!taken) begin
         report_timeout("a read to be accepted");
      end else begin
         waited = 0;
         @(negedge aclk);
         while (!s_axi_lite_rvalid && waited < TIMEOUT_CYCLES) begin
            @(negedge aclk);
            waited++;
         end
         if (s_axi_lite_rvalid) begin
            data = s_axi_lite_rdata;
            resp = s_axi_lite_rresp;
         end else begin
            report_timeout("read data");
         end
         @(posedge aclk);
         #2;
      end
   endtask

   task automatic write_okay(input lite_addr_t addr, input lite_data_t data);
      resp_t resp;
      lite_write(addr, data, resp);
      check_equal("bresp", resp, RESP_OKAY);
   endtask

   // Key words, start pulse, then STATUS polling
   task automatic load_key(input aes_key_t k);
      lite_data_t rd;
      resp_t resp;
      int polls;
      for (int i = 0; i < 4; i++)
         write_okay(lite_addr_t'(`REG_KEY0 + 4 * i), k[127-32*i -: 32]);
      write_okay(`REG_CTRL, 32'h1);
      // No input while the schedule runs
      check_equal("m_axis_mm2s_tready", m_axis_mm2s_tready, 1'b0);
      lite_read(`REG_STATUS, rd, resp);
      check_equal("STATUS busy", rd, 32'h2);
      polls = 0;
      while (rd[0] !== 1'b1 && polls < STATUS_POLLS) begin
         lite_read(`REG_STATUS, rd, resp);
         polls++;
      end
      if (rd[0] !== 1'b1)
         report_timeout("key_ready in STATUS");
      check_equal("STATUS ready", rd, 32'h1);
      cur_key = k;
   endtask

   // Expected result queued once the input beat is accepted
   task automatic send_block(input aes_block_t data, input logic last);
      int waited;
      waited = 0;
      m_axis_mm2s_tdata = data;
      m_axis_mm2s_tlast = last;
      m_axis_mm2s_tvalid = 1'b1;
      @(negedge aclk);
      while (!m_axis_mm2s_tready && waited < TIMEOUT_CYCLES) begin
         @(negedge aclk);
         waited++;
      end
      if (m_axis_mm2s_tready)
         exp_q.push_back({last, aes_ref(data, cur_key)});
      else
         report_timeout("m_axis_mm2s_tready");
      @(posedge aclk);
      #2;
      m_axis_mm2s_tvalid = 1'b0;
   endtask

   task automatic send_random(input int n);
      for (int i = 0; i < n; i++)
         send_block(random_word128(), $random(seed) & 1);
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
         @(negedge aclk);
         waited++;
      end
      if (exp_q.size() != 0)
         report_timeout("the pipeline to drain");
      @(posedge aclk);
      #2;
   endtask

   task automatic check_count();
      lite_data_t rd;
      resp_t resp;
      lite_read(`REG_COUNT, rd, resp);
      check_equal("COUNT", rd, seen_count);
   endtask

   initial begin
      aclk = 1'b0;
      forever #10 aclk = ~aclk;
   end

   // Random output stalls
   initial begin
      forever begin
         @(posedge aclk);
         #2;
         if (bp_on)
            s_axis_s2mm_tready = $random(seed) & 1;
      end
   end

   // Scoreboard sampling the output mid-cycle
   initial begin
      logic [`AES_BLOCK_W:0] entry;
      prev_stall = 1'b0;
      forever begin
         @(negedge aclk);
         if (!reset) begin
            if (prev_stall) begin
               check_equal("s2mm_tvalid held", s_axis_s2mm_tvalid, 1'b1);
               check_equal("s2mm_tdata held", s_axis_s2mm_tdata, prev_data);
               check_equal("s2mm_tlast held", s_axis_s2mm_tlast, prev_last);
            end
            if (s_axis_s2mm_tvalid && s_axis_s2mm_tready) begin
               seen_count++;
               if (exp_q.size() == 0) begin
                  errors++;
                  $display("Output beat at %0t with no block in flight", $time);
               end else begin
                  entry = exp_q.pop_front();
                  check_equal("s2mm_tdata", s_axis_s2mm_tdata, entry[`AES_BLOCK_W-1:0]);
                  check_equal("s2mm_tlast", s_axis_s2mm_tlast, entry[`AES_BLOCK_W]);
               end
            end
            prev_stall = s_axis_s2mm_tvalid && !s_axis_s2mm_tready;
            prev_data = s_axis_s2mm_tdata;
            prev_last = s_axis_s2mm_tlast;
         end
      end
   end

   initial begin
      lite_data_t rd;
      resp_t resp;
      aes_key_t fips_key;
      aes_block_t fips_pt;
      aes_block_t fips_ct;
      fips_key = 128'h000102030405060708090a0b0c0d0e0f;
      fips_pt = 128'h00112233445566778899aabbccddeeff;
      fips_ct = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
      reset = 1'b1;
      s_axi_lite_awvalid = 1'b0;
      s_axi_lite_awaddr = '0;
      s_axi_lite_wvalid = 1'b0;
      s_axi_lite_wdata = '0;
      s_axi_lite_bready = 1'b1;
      s_axi_lite_arvalid = 1'b0;
      s_axi_lite_araddr = '0;
      s_axi_lite_rready = 1'b1;
      m_axis_mm2s_tdata = '0;
      m_axis_mm2s_tvalid = 1'b0;
      m_axis_mm2s_tlast = 1'b0;
      s_axis_s2mm_tready = 1'b1;
      cur_key = '0;
      repeat (5) @(posedge aclk);
      #2;
      reset = 1'b0;

      // Register map before any key load
      @(negedge aclk);
      check_equal("m_axis_mm2s_tready", m_axis_mm2s_tready, 1'b0);
      @(posedge aclk);
      #2;
      load_key(fips_key);
      for (int i = 0; i < 4; i++) begin
         lite_read(lite_addr_t'(`REG_KEY0 + 4 * i), rd, resp);
         check_equal("KEY readback", rd, fips_key[127-32*i -: 32]);
      end
      lite_write(10'h020, 32'hdeadbeef, resp);
      check_equal("bresp unmapped", resp, RESP_SLVERR);
      lite_read(10'h3fc, rd, resp);
      check_equal("rresp unmapped", resp, RESP_SLVERR);
      lite_write(`REG_STATUS, 32'h3, resp);
      check_equal("bresp STATUS", resp, RESP_OKAY);
      lite_read(`REG_KEY0, rd, resp);
      check_equal("KEY0 after stray writes", rd, fips_key[127:96]);

      // FIPS-197 vector
      check_equal("aes_ref FIPS-197", aes_ref(fips_pt, fips_key), fips_ct);
      exp_q.delete();
      send_block(fips_pt, 1'b1);
      wait_drain();
      check_count();

      // Throughput under a random key
      load_key(random_word128());
      send_random(40);
      wait_drain();
      check_count();

      // Back-pressure
      bp_on = 1'b1;
      send_random(30);
      bp_on = 1'b0;
      s_axis_s2mm_tready = 1'b1;
      wait_drain();
      check_count();

      // Re-key after the drain
      load_key(random_word128());
      send_random(20);
      wait_drain();
      check_count();

      $display("checks %0d, errors %0d, blocks %0d", checks, errors, seen_count);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
hw/axi_pkg.sv
hw/aes_pkg.sv
hw/aes_stage_if.sv
hw/aes_lite_regs.sv
hw/aes_key_schedule.sv
hw/aes_ingress.sv
hw/aes_round.sv
hw/aes_egress.sv
hw/axi_aes.sv
sim/tb_axi_aes.sv

/* Bender.yml */
package:
  name: axi_aes

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/axi_pkg.sv
      - hw/aes_pkg.sv
      - hw/aes_stage_if.sv
      - hw/aes_lite_regs.sv
      - hw/aes_key_schedule.sv
      - hw/aes_ingress.sv
      - hw/aes_round.sv
      - hw/aes_egress.sv
      - hw/axi_aes.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_axi_aes.sv
